/* include/opll_reg_consts.svh */
`ifndef OPLL_REG_CONSTS_SVH
`define OPLL_REG_CONSTS_SVH

// channel layout
`define OPLL_NUM_CH         9
`define OPLL_RHY_CH         6       // first channel taken over by rhythm mode

// register map
`define OPLL_ADDR_RHYTHM    8'h0E
`define OPLL_GRP_FNUM       4'h1    // 0x10..0x18
`define OPLL_GRP_KON        4'h2    // 0x20..0x28
`define OPLL_GRP_VOL        4'h3    // 0x30..0x38

// percussion rows behind the melodic patches
`define OPLL_PERC_ROW_BD0   5'd16
`define OPLL_PERC_ROW_HH    5'd17
`define OPLL_PERC_ROW_TT    5'd18
`define OPLL_PERC_ROW_BD1   5'd19
`define OPLL_PERC_ROW_SD    5'd20
`define OPLL_PERC_ROW_TC    5'd21

`define OPLL_SYNC_STAGES    2

// patch word field lsb, pairs keep the carrier at the lsb
`define F_RR                0
`define F_SL                8
`define F_DR                16
`define F_AR                24
`define F_KSL               32
`define F_MUL               36
`define F_KSR               44
`define F_ETYP              46
`define F_PM                48
`define F_AM                50
`define F_FB                52
`define F_DM                55
`define F_DC                56
`define F_TL                57

`endif

/* logic/opll_reg_pkg.sv */
package opll_reg_pkg;

// bus side
typedef logic [7:0]     reg_data_t;
typedef logic [7:0]     reg_addr_t;

// channel fields
typedef logic [3:0]     chan_t;
typedef logic [8:0]     fnum_t;
typedef logic [2:0]     block_t;
typedef logic [3:0]     nib_t;      // volume or instrument number

// operator fields
typedef logic [5:0]     tl_t;
typedef logic [3:0]     rate_t;
typedef logic [3:0]     mul_t;
typedef logic [1:0]     ksl_t;
typedef logic [2:0]     fb_t;

// bit 5 enable, bits 4..0 bd sd tt tc hh
typedef logic [5:0]     rhythm_t;

// patch storage
typedef logic [4:0]     rom_addr_t;
typedef logic [62:0]    patch_word_t;

endpackage

/* logic/opll_bus_sync.sv */
`timescale 1ns/100ps
`include "opll_reg_consts.svh"

module opll_bus_sync (
    input   logic                       i_EMUCLK,
    input   logic                       i_IC_n,
    input   logic                       i_CS_n,
    input   logic                       i_WR_n,
    input   logic                       i_A0,
    input   opll_reg_pkg::reg_data_t    i_D,
    output  logic                       o_addr_wr,
    output  logic                       o_data_wr,
    output  opll_reg_pkg::reg_addr_t    o_reg_addr,
    output  opll_reg_pkg::reg_data_t    o_wdata
);

import opll_reg_pkg::*;

logic   [`OPLL_SYNC_STAGES-1:0] cs_n_sync, wr_n_sync, a0_sync;
reg_data_t                      d_sync [`OPLL_SYNC_STAGES];

// last stage of each chain
logic       cs_n, wr_n, a0;
reg_data_t  din;
logic       wr_req, wr_req_z, wr_edge;

assign cs_n    = cs_n_sync[`OPLL_SYNC_STAGES-1];
assign wr_n    = wr_n_sync[`OPLL_SYNC_STAGES-1];
assign a0      = a0_sync[`OPLL_SYNC_STAGES-1];
assign din     = d_sync[`OPLL_SYNC_STAGES-1];

assign wr_req  = ~cs_n & ~wr_n;
assign wr_edge = wr_req & ~wr_req_z;    // one pulse per bus cycle

always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
    if (!i_IC_n) begin
        cs_n_sync  <= '1;   // idle bus
        wr_n_sync  <= '1;
        a0_sync    <= '0;
        wr_req_z   <= 1'b0;
        o_addr_wr  <= 1'b0;
        o_data_wr  <= 1'b0;
        o_reg_addr <= '0;
    end else begin
        cs_n_sync  <= {cs_n_sync[`OPLL_SYNC_STAGES-2:0], i_CS_n};
        wr_n_sync  <= {wr_n_sync[`OPLL_SYNC_STAGES-2:0], i_WR_n};
        a0_sync    <= {a0_sync[`OPLL_SYNC_STAGES-2:0], i_A0};
        wr_req_z   <= wr_req;
        o_addr_wr  <= wr_edge & ~a0;
        o_data_wr  <= wr_edge & a0;
        if (wr_edge && !a0) begin
            o_reg_addr <= din;
        end
    end
end

// data path, loaded alongside either strobe
always_ff @(posedge i_EMUCLK) begin
    d_sync[0] <= i_D;
    for (int i = 1; i < `OPLL_SYNC_STAGES; i++) begin
        d_sync[i] <= d_sync[i-1];
    end
    if (wr_edge) begin
        o_wdata <= din;
    end
end

endmodule

/* logic/opll_cust_patch_regs.sv */
`timescale 1ns/100ps
`include "opll_reg_consts.svh"

module opll_cust_patch_regs (
    input   logic                       i_EMUCLK,
    input   logic                       i_IC_n,
    input   logic                       i_data_wr,
    input   opll_reg_pkg::reg_addr_t    i_reg_addr,
    input   opll_reg_pkg::reg_data_t    i_wdata,
    output  opll_reg_pkg::patch_word_t  o_cust_patch,
    output  opll_reg_pkg::rhythm_t      o_rhythm
);

import opll_reg_pkg::*;

reg_data_t  inst_reg [8];   // 0x00..0x07 as written

always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
    if (!i_IC_n) begin
        for (int i = 0; i < 8; i++) begin
            inst_reg[i] <= '0;
        end
        o_rhythm <= '0;
    end else if (i_data_wr) begin
        if (i_reg_addr[7:3] == 5'b00000) begin
            inst_reg[i_reg_addr[2:0]] <= i_wdata;
        end
        if (i_reg_addr == `OPLL_ADDR_RHYTHM) begin
            o_rhythm <= i_wdata[5:0];
        end
    end
end

////////////////////////////////////////
// repack into the rom word layout
////////////////////////////////////////

always_comb begin
    // single fields, reg 3 bit 5 has no function
    o_cust_patch[`F_TL +: 6]  = inst_reg[2][5:0];
    o_cust_patch[`F_DC]       = inst_reg[3][4];
    o_cust_patch[`F_DM]       = inst_reg[3][3];
    o_cust_patch[`F_FB +: 3]  = inst_reg[3][2:0];

    // pairs, modulator from the even register
    o_cust_patch[`F_AM +: 2]   = {inst_reg[0][7], inst_reg[1][7]};
    o_cust_patch[`F_PM +: 2]   = {inst_reg[0][6], inst_reg[1][6]};
    o_cust_patch[`F_ETYP +: 2] = {inst_reg[0][5], inst_reg[1][5]};
    o_cust_patch[`F_KSR +: 2]  = {inst_reg[0][4], inst_reg[1][4]};
    o_cust_patch[`F_MUL +: 8]  = {inst_reg[0][3:0], inst_reg[1][3:0]};
    o_cust_patch[`F_KSL +: 4]  = {inst_reg[2][7:6], inst_reg[3][7:6]};  // carrier ksl in reg 3
    o_cust_patch[`F_AR +: 8]   = {inst_reg[4][7:4], inst_reg[5][7:4]};
    o_cust_patch[`F_DR +: 8]   = {inst_reg[4][3:0], inst_reg[5][3:0]};
    o_cust_patch[`F_SL +: 8]   = {inst_reg[6][7:4], inst_reg[7][7:4]};
    o_cust_patch[`F_RR +: 8]   = {inst_reg[6][3:0], inst_reg[7][3:0]};
end

endmodule

/* logic/opll_chan_regs.sv */
`timescale 1ns/100ps
`include "opll_reg_consts.svh"

module opll_chan_regs (
    input   logic                       i_EMUCLK,
    input   logic                       i_IC_n,
    input   logic                       i_data_wr,
    input   opll_reg_pkg::reg_addr_t    i_reg_addr,
    input   opll_reg_pkg::reg_data_t    i_wdata,
    input   opll_reg_pkg::chan_t        i_ch,
    output  opll_reg_pkg::fnum_t        o_fnum,
    output  opll_reg_pkg::block_t       o_block,
    output  logic                       o_kon,
    output  logic                       o_susen,
    output  opll_reg_pkg::nib_t         o_vol,
    output  opll_reg_pkg::nib_t         o_inst
);

import opll_reg_pkg::*;

fnum_t      fnum  [`OPLL_NUM_CH];
block_t     block [`OPLL_NUM_CH];
logic       kon   [`OPLL_NUM_CH];
logic       susen [`OPLL_NUM_CH];
nib_t       vol   [`OPLL_NUM_CH];
nib_t       inst  [`OPLL_NUM_CH];

chan_t      wr_ch;
logic       wr_ok, rd_ok;

assign wr_ch = i_reg_addr[3:0];
assign wr_ok = i_data_wr && (wr_ch < chan_t'(`OPLL_NUM_CH));    // x9..xF ignored
assign rd_ok = i_ch < chan_t'(`OPLL_NUM_CH);

always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
    if (!i_IC_n) begin
        for (int i = 0; i < `OPLL_NUM_CH; i++) begin
            fnum[i]  <= '0;
            block[i] <= '0;
            kon[i]   <= 1'b0;
            susen[i] <= 1'b0;
            vol[i]   <= '0;
            inst[i]  <= '0;
        end
    end else if (wr_ok) begin
        case (i_reg_addr[7:4])
            `OPLL_GRP_FNUM: fnum[wr_ch][7:0] <= i_wdata;
            `OPLL_GRP_KON: begin
                {susen[wr_ch], kon[wr_ch], block[wr_ch], fnum[wr_ch][8]} <= i_wdata[5:0];
            end
            `OPLL_GRP_VOL: {inst[wr_ch], vol[wr_ch]} <= i_wdata;
            default: ;
        endcase
    end
end

// read port, nonexistent channels read as zero
assign o_fnum  = rd_ok ? fnum[i_ch]  : '0;
assign o_block = rd_ok ? block[i_ch] : '0;
assign o_kon   = rd_ok ? kon[i_ch]   : 1'b0;
assign o_susen = rd_ok ? susen[i_ch] : 1'b0;
assign o_vol   = rd_ok ? vol[i_ch]   : '0;
assign o_inst  = rd_ok ? inst[i_ch]  : '0;

endmodule

/* logic/opll_patch_rom.sv */
`timescale 1ns/100ps

module opll_patch_rom (
    input   logic                       i_EMUCLK,
    input   opll_reg_pkg::rom_addr_t    i_rom_addr,
    output  opll_reg_pkg::patch_word_t  o_patch_word
);

import opll_reg_pkg::*;

patch_word_t    rom_q;

assign o_patch_word = rom_q;

// synchronous read, maps onto a block ram
always_ff @(posedge i_EMUCLK) begin
    case (i_rom_addr)
        //      TL     DDFB  AMPMETKR  MUL      KSL  AR       DR       SL       RR
        // melodic patches 1..15
        5'd1:  rom_q <= 63'b011110_10111_00111110_00010001_0000_11010111_00001000_00000001_00000111;
        5'd2:  rom_q <= 63'b011010_01101_00010010_00110001_0000_11011111_10000111_00100001_00110011;
        5'd3:  rom_q <= 63'b011001_00000_00000010_00110001_1000_11111100_00100100_00010010_00010011;
        5'd4:  rom_q <= 63'b001110_00111_00011110_00010001_0000_10100110_10000100_01110010_00000111;
        5'd5:  rom_q <= 63'b011110_00110_00001110_00100001_0000_11100111_00000110_00000010_00001000;
        5'd6:  rom_q <= 63'b010110_00101_00001110_00010010_0000_11100111_00000001_00000001_00001000;
        5'd7:  rom_q <= 63'b011101_00111_00011100_00010001_0000_10001000_00100001_00010000_00000111;
        5'd8:  rom_q <= 63'b101101_10100_00001100_00110001_0000_10100111_00100010_00000000_00000111;
        5'd9:  rom_q <= 63'b011011_00110_00111100_00010001_0000_01100110_01000101_00010001_00000111;
        5'd10: rom_q <= 63'b001011_11000_00110100_00010001_0000_10001111_01010111_01110000_00010111;
        5'd11: rom_q <= 63'b000011_10001_00000010_00110001_1000_11111110_10100100_00010000_00000100;
        5'd12: rom_q <= 63'b100100_00111_01010010_01110001_0000_11111111_10001000_00100001_00100010;
        5'd13: rom_q <= 63'b001100_00101_00111001_00010000_0000_11001111_00100101_00100100_00000010;
        5'd14: rom_q <= 63'b010101_00011_00000000_00010001_0100_11001001_10010101_00000000_00110010;
        5'd15: rom_q <= 63'b001001_00011_00111000_00010001_1000_11111110_00010100_01000001_00000011;
        // drum rows bd0, hh, tt, bd1, sd, tc
        5'd16: rom_q <= 63'b011000_01111_00000000_00010000_0000_11010000_11110000_01100000_10100000;
        5'd17: rom_q <= 63'b000000_00000_00000000_00010000_0000_11000000_10000000_10100000_01110000;
        5'd18: rom_q <= 63'b000000_00000_00000000_01010000_0000_11110000_10000000_01010000_10010000;
        5'd19: rom_q <= 63'b000000_00000_00000000_00000001_0000_00001111_00001000_00000110_00001101;
        5'd20: rom_q <= 63'b000000_00000_00000000_00000001_0000_00001101_00001000_00000100_00001000;
        5'd21: rom_q <= 63'b000000_00000_00000000_00000001_0000_00001010_00001010_00000101_00000101;
        default: rom_q <= '0;   // row 0 and unused rows
    endcase
end

endmodule

/* logic/opll_param_select.sv */
`timescale 1ns/100ps
`include "opll_reg_consts.svh"

module opll_param_select (
    input   logic                       i_EMUCLK,
    input   logic                       i_IC_n,
    input   opll_reg_pkg::chan_t        i_ch,
    input   logic                       i_mnc_sel,      // 1 = modulator
    input   opll_reg_pkg::rhythm_t      i_rhythm,
    input   opll_reg_pkg::patch_word_t  i_cust_patch,
    input   opll_reg_pkg::patch_word_t  i_patch_word,
    input   opll_reg_pkg::fnum_t        i_fnum,
    input   opll_reg_pkg::block_t       i_block,
    input   logic                       i_kon,
    input   logic                       i_susen,
    input   opll_reg_pkg::nib_t         i_vol,
    input   opll_reg_pkg::nib_t         i_inst,
    output  opll_reg_pkg::rom_addr_t    o_rom_addr,
    output  opll_reg_pkg::fnum_t        o_fnum,
    output  opll_reg_pkg::block_t       o_block,
    output  logic                       o_kon,
    output  logic                       o_susen,
    output  opll_reg_pkg::tl_t          o_tl,
    output  logic                       o_dc,
    output  logic                       o_dm,
    output  opll_reg_pkg::fb_t          o_fb,
    output  logic                       o_am,
    output  logic                       o_pm,
    output  logic                       o_etyp,
    output  logic                       o_ksr,
    output  opll_reg_pkg::mul_t         o_mul,
    output  opll_reg_pkg::ksl_t         o_ksl,
    output  opll_reg_pkg::rate_t        o_ar,
    output  opll_reg_pkg::rate_t        o_dr,
    output  opll_reg_pkg::rate_t        o_sl,
    output  opll_reg_pkg::rate_t        o_rr
);

import opll_reg_pkg::*;

////////////////////////////////////////
// percussion decode
////////////////////////////////////////

logic       is_perc;
logic       is_hhtt;    // drum slots whose tl comes from the inst nibble
logic       drum_kon;
rom_addr_t  perc_row;

always_comb begin
    is_perc  = i_rhythm[5];
    perc_row = `OPLL_PERC_ROW_BD0;
    drum_kon = 1'b0;
    case (i_ch)
        chan_t'(`OPLL_RHY_CH): begin
            perc_row = i_mnc_sel ? `OPLL_PERC_ROW_BD0 : `OPLL_PERC_ROW_BD1;
            drum_kon = i_rhythm[4];
        end
        chan_t'(`OPLL_RHY_CH + 1): begin
            perc_row = i_mnc_sel ? `OPLL_PERC_ROW_HH : `OPLL_PERC_ROW_SD;
            drum_kon = i_mnc_sel ? i_rhythm[0] : i_rhythm[3];
        end
        chan_t'(`OPLL_RHY_CH + 2): begin
            perc_row = i_mnc_sel ? `OPLL_PERC_ROW_TT : `OPLL_PERC_ROW_TC;
            drum_kon = i_mnc_sel ? i_rhythm[2] : i_rhythm[1];
        end
        default: is_perc = 1'b0;
    endcase
end

assign is_hhtt    = is_perc & i_mnc_sel & (i_ch != chan_t'(`OPLL_RHY_CH));
assign o_rom_addr = is_perc ? perc_row : {1'b0, i_inst};

////////////////////////////////////////
// stage, lines up with the rom read
////////////////////////////////////////

logic       q_mnc, q_cust, q_hhtt, q_drum_kon;
fnum_t      q_fnum;
block_t     q_block;
logic       q_kon, q_susen;
nib_t       q_vol, q_inst;

always_ff @(posedge i_EMUCLK or negedge i_IC_n) begin
    if (!i_IC_n) begin
        q_mnc      <= 1'b0;
        q_cust     <= 1'b0;
        q_hhtt     <= 1'b0;
        q_drum_kon <= 1'b0;
        q_fnum     <= '0;
        q_block    <= '0;
        q_kon      <= 1'b0;
        q_susen    <= 1'b0;
        q_vol      <= '0;
        q_inst     <= '0;
    end else begin
        q_mnc      <= i_mnc_sel;
        q_cust     <= ~is_perc & (i_inst == 4'h0);  // instrument 0 plays the user patch
        q_hhtt     <= is_hhtt;
        q_drum_kon <= is_perc & drum_kon;
        q_fnum     <= i_fnum;
        q_block    <= i_block;
        q_kon      <= i_kon;
        q_susen    <= i_susen;
        q_vol      <= i_vol;
        q_inst     <= i_inst;
    end
end

////////////////////////////////////////
// output selection
////////////////////////////////////////

patch_word_t    pw;
logic           rate_zero;

assign pw      = q_cust ? i_cust_patch : i_patch_word;

assign o_fnum  = q_fnum;
assign o_block = q_block;
assign o_susen = q_susen;
assign o_kon   = q_kon | q_drum_kon;

// whole fields, no operator half
assign o_dc    = pw[`F_DC];
assign o_dm    = pw[`F_DM];
assign o_fb    = pw[`F_FB +: 3];
assign o_tl    = q_hhtt ? {q_inst, 2'b00} :
                 !q_mnc ? {q_vol, 2'b00}  : pw[`F_TL +: 6];

// modulator half sits above the carrier half
assign o_am    = q_mnc ? pw[`F_AM + 1]   : pw[`F_AM];
assign o_pm    = q_mnc ? pw[`F_PM + 1]   : pw[`F_PM];
assign o_etyp  = q_mnc ? pw[`F_ETYP + 1] : pw[`F_ETYP];
assign o_ksr   = q_mnc ? pw[`F_KSR + 1]  : pw[`F_KSR];
assign o_mul   = q_mnc ? pw[(`F_MUL + 4) +: 4] : pw[`F_MUL +: 4];
assign o_ksl   = q_mnc ? pw[(`F_KSL + 2) +: 2] : pw[`F_KSL +: 2];
assign o_sl    = q_mnc ? pw[(`F_SL + 4) +: 4]  : pw[`F_SL +: 4];

// idle modulators are held off, hh and tt run free
assign rate_zero = q_mnc & ~q_hhtt & ~o_kon;

assign o_ar    = rate_zero ? '0 : (q_mnc ? pw[(`F_AR + 4) +: 4] : pw[`F_AR +: 4]);
assign o_dr    = rate_zero ? '0 : (q_mnc ? pw[(`F_DR + 4) +: 4] : pw[`F_DR +: 4]);
assign o_rr    = rate_zero ? '0 : (q_mnc ? pw[(`F_RR + 4) +: 4] : pw[`F_RR +: 4]);

endmodule

/* logic/opll_reg_top.sv */
`timescale 1ns/100ps

module opll_reg_top (
    input   logic                       i_EMUCLK,
    input   logic                       i_IC_n,
    // cpu bus
    input   logic                       i_CS_n,
    input   logic                       i_WR_n,
    input   logic                       i_A0,
    input   opll_reg_pkg::reg_data_t    i_D,
    // operator query
    input   opll_reg_pkg::chan_t        i_ch,
    input   logic                       i_mnc_sel,
    output  logic                       o_rhythm_en,
    output  opll_reg_pkg::fnum_t        o_fnum,
    output  opll_reg_pkg::block_t       o_block,
    output  logic                       o_kon,
    output  logic                       o_susen,
    output  opll_reg_pkg::tl_t          o_tl,
    output  logic                       o_dc,
    output  logic                       o_dm,
    output  opll_reg_pkg::fb_t          o_fb,
    output  logic                       o_am,
    output  logic                       o_pm,
    output  logic                       o_etyp,
    output  logic                       o_ksr,
    output  opll_reg_pkg::mul_t         o_mul,
    output  opll_reg_pkg::ksl_t         o_ksl,
    output  opll_reg_pkg::rate_t        o_ar,
    output  opll_reg_pkg::rate_t        o_dr,
    output  opll_reg_pkg::rate_t        o_sl,
    output  opll_reg_pkg::rate_t        o_rr
);

import opll_reg_pkg::*;

logic           data_wr;
reg_addr_t      reg_addr;
reg_data_t      wdata;
patch_word_t    cust_patch, patch_word;
rhythm_t        rhythm;
rom_addr_t      rom_addr;
fnum_t          ch_fnum;
block_t         ch_block;
logic           ch_kon, ch_susen;
nib_t           ch_vol, ch_inst;

assign o_rhythm_en = rhythm[5];

////////////////////////////////////////
// write side
////////////////////////////////////////

opll_bus_sync u_bus_sync (
    .i_EMUCLK(i_EMUCLK), .i_IC_n(i_IC_n),
    .i_CS_n(i_CS_n), .i_WR_n(i_WR_n), .i_A0(i_A0), .i_D(i_D),
    .o_addr_wr(), .o_data_wr(data_wr),
    .o_reg_addr(reg_addr), .o_wdata(wdata)
);

opll_cust_patch_regs u_cust_regs (
    .i_EMUCLK(i_EMUCLK), .i_IC_n(i_IC_n),
    .i_data_wr(data_wr), .i_reg_addr(reg_addr), .i_wdata(wdata),
    .o_cust_patch(cust_patch), .o_rhythm(rhythm)
);

opll_chan_regs u_chan_regs (
    .i_EMUCLK(i_EMUCLK), .i_IC_n(i_IC_n),
    .i_data_wr(data_wr), .i_reg_addr(reg_addr), .i_wdata(wdata), .i_ch(i_ch),
    .o_fnum(ch_fnum), .o_block(ch_block), .o_kon(ch_kon), .o_susen(ch_susen),
    .o_vol(ch_vol), .o_inst(ch_inst)
);

////////////////////////////////////////
// query side
////////////////////////////////////////

opll_patch_rom u_patch_rom (
    .i_EMUCLK(i_EMUCLK), .i_rom_addr(rom_addr), .o_patch_word(patch_word)
);

opll_param_select u_param_sel (
    .i_EMUCLK(i_EMUCLK), .i_IC_n(i_IC_n),
    .i_ch(i_ch), .i_mnc_sel(i_mnc_sel), .i_rhythm(rhythm),
    .i_cust_patch(cust_patch), .i_patch_word(patch_word),
    .i_fnum(ch_fnum), .i_block(ch_block), .i_kon(ch_kon), .i_susen(ch_susen),
    .i_vol(ch_vol), .i_inst(ch_inst),
    .o_rom_addr(rom_addr),
    .o_fnum(o_fnum), .o_block(o_block), .o_kon(o_kon), .o_susen(o_susen),
    .o_tl(o_tl), .o_dc(o_dc), .o_dm(o_dm), .o_fb(o_fb),
    .o_am(o_am), .o_pm(o_pm), .o_etyp(o_etyp), .o_ksr(o_ksr),
    .o_mul(o_mul), .o_ksl(o_ksl),
    .o_ar(o_ar), .o_dr(o_dr), .o_sl(o_sl), .o_rr(o_rr)
);

endmodule

/* verif/opll_reg_checker.sv */
`timescale 1ns/100ps

module opll_reg_checker (
    input   logic   i_EMUCLK,
    input   logic   i_IC_n,
    input   logic   o_addr_wr,
    input   logic   o_data_wr
);

int fail_cnt = 0;   // read by the testbench at the end of the run

// address and data strobes are mutually exclusive
a_excl: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
    !(o_addr_wr && o_data_wr))
    else begin fail_cnt++; $error("address and data strobes high together"); end

// single-cycle pulses only
a_addr_pulse: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
    o_addr_wr |=> !o_addr_wr)
    else begin fail_cnt++; $error("address strobe longer than one cycle"); end

a_data_pulse: assert property (@(posedge i_EMUCLK) disable iff (!i_IC_n)
    o_data_wr |=> !o_data_wr)
    else begin fail_cnt++; $error("data strobe longer than one cycle"); end

a_reset_quiet: assert property (@(posedge i_EMUCLK)
    !i_IC_n |-> (!o_addr_wr && !o_data_wr))
    else begin fail_cnt++; $error("strobe active during reset"); end

endmodule

bind opll_bus_sync opll_reg_checker u_checker (.*);

/* verif/opll_reg_tb.sv */
`timescale 1ns/100ps
`include "opll_reg_consts.svh"

module opll_reg_tb;

import opll_reg_pkg::*;

localparam int N_PAT          = 10;
localparam int PAT_COLS       = 9;
localparam int N_REG_WRITES   = 30 + N_PAT;     // addr + data pairs, 22 clocks each
localparam int N_QUERIES      = 38 + N_PAT;     // 2 clocks each
localparam int CLK_NS         = 40;
localparam int TIMEOUT_CYC    = 16 + N_REG_WRITES * 22 + N_QUERIES * 2 + 200;

logic       clk = 1'b0;
logic       ic_n, cs_n, wr_n, a0, mnc_sel;
reg_data_t  d;
chan_t      ch;
logic       rhythm_en, kon, susen, dc, dm, am, pm, etyp, ksr;
fnum_t      fnum;
block_t     block;
tl_t        tl;
fb_t        fb;
mul_t       mul;
ksl_t       ksl;
rate_t      ar, dr, sl, rr;

int         errors = 0;
int         other_errors = 0;
logic [15:0] lfsr_state = 16'd41;
logic [7:0] pat_mem [0:N_PAT*PAT_COLS-1];

// shadow of the channel registers
fnum_t      m_fnum [`OPLL_NUM_CH];
block_t     m_block [`OPLL_NUM_CH];
logic       m_kon [`OPLL_NUM_CH];
logic       m_sus [`OPLL_NUM_CH];

always #(CLK_NS/2) clk = ~clk;

opll_reg_top DUT (
    .i_EMUCLK(clk), .i_IC_n(ic_n), .i_CS_n(cs_n), .i_WR_n(wr_n), .i_A0(a0), .i_D(d),
    .i_ch(ch), .i_mnc_sel(mnc_sel), .o_rhythm_en(rhythm_en),
    .o_fnum(fnum), .o_block(block), .o_kon(kon), .o_susen(susen),
    .o_tl(tl), .o_dc(dc), .o_dm(dm), .o_fb(fb), .o_am(am), .o_pm(pm),
    .o_etyp(etyp), .o_ksr(ksr), .o_mul(mul), .o_ksl(ksl),
    .o_ar(ar), .o_dr(dr), .o_sl(sl), .o_rr(rr)
);

////////////////////////////////////////
// stimulus helpers
////////////////////////////////////////

// x^16 + x^14 + x^13 + x^11
function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    logic       nb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        nb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], nb};
        v = {v[6:0], nb};
    end
    return v;
endfunction

task automatic bus_write(input logic sel_a0, input reg_data_t val);
    @(negedge clk);
    cs_n = 1'b0;
    a0   = sel_a0;
    d    = val;
    wr_n = 1'b0;
    repeat (3) @(negedge clk);
    wr_n = 1'b1;
    cs_n = 1'b1;
    repeat (3) @(negedge clk);
    repeat (4) @(negedge clk);  // register update lands in here
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t val);
    bus_write(1'b0, addr);
    bus_write(1'b1, val);
endtask

// outputs belong to the query of the previous clock
task automatic query(input int c, input logic sel);
    @(negedge clk);
    ch      = chan_t'(c);
    mnc_sel = sel;
    @(negedge clk);
endtask

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_tl(input string name, input tl_t got, input tl_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_rate(input string name, input rate_t got, input rate_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_mul(input string name, input mul_t got, input mul_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_ksl(input string name, input ksl_t got, input ksl_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_fb(input string name, input fb_t got, input fb_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_fnum(input string name, input fnum_t got, input fnum_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_rates(input rate_t e_ar, input rate_t e_dr, input rate_t e_sl,
                           input rate_t e_rr);
    check_rate("o_ar", ar, e_ar);
    check_rate("o_dr", dr, e_dr);
    check_rate("o_sl", sl, e_sl);
    check_rate("o_rr", rr, e_rr);
endtask

////////////////////////////////////////
// watchdog
////////////////////////////////////////

initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, test sequence did not finish", TIMEOUT_CYC);
    $display("Simulation FAILED");
    $finish;
end

////////////////////////////////////////
// test sequence
////////////////////////////////////////

initial begin
    reg_data_t  r [8];
    reg_data_t  b2;
    int         c;
    nib_t       inst_n;
    logic       sel;

    ic_n = 1'b0;
    cs_n = 1'b1;
    wr_n = 1'b1;
    a0 = 1'b0;
    d = '0;
    ch = '0;
    mnc_sel = 1'b0;
    for (int i = 0; i < `OPLL_NUM_CH; i++) begin
        m_fnum[i] = '0;
        m_block[i] = '0;
        m_kon[i] = 1'b0;
        m_sus[i] = 1'b0;
    end
    $readmemh("verif/opll_reg_patterns.txt", pat_mem);
    repeat (16) @(posedge clk);
    @(negedge clk);
    ic_n = 1'b1;

    // reset state
    for (int i = 0; i < `OPLL_NUM_CH; i++) begin
        for (int s = 0; s < 2; s++) begin
            query(i, s[0]);
            check_bit("o_kon", kon, 1'b0);
            check_bit("o_rhythm_en", rhythm_en, 1'b0);
            check_tl("o_tl", tl, '0);
            check_fb("o_fb", fb, '0);
            check_rates('0, '0, '0, '0);
        end
    end

    // channel registers on random channels
    for (int n = 0; n < 3; n++) begin
        c = int'(rand_bits(4)) % `OPLL_NUM_CH;
        r[0] = rand_bits(8);
        b2 = rand_bits(8);
        write_reg({`OPLL_GRP_FNUM, 4'(c)}, r[0]);
        write_reg({`OPLL_GRP_KON, 4'(c)}, b2);
        write_reg({`OPLL_GRP_VOL, 4'(c)}, rand_bits(8));
        m_fnum[c]  = {b2[0], r[0]};
        m_block[c] = b2[3:1];
        m_kon[c]   = b2[4];
        m_sus[c]   = b2[5];
    end
    for (int i = 0; i < `OPLL_NUM_CH; i++) begin
        query(i, 1'b0);
        check_fnum("o_fnum", fnum, m_fnum[i]);
        check_block("o_block", block, m_block[i]);
        check_bit("o_kon", kon, m_kon[i]);
        check_bit("o_susen", susen, m_sus[i]);
    end

    // custom instrument on channel 0, volume A
    write_reg(8'h30, 8'h0A);
    write_reg(8'h20, 8'h10);
    for (int i = 0; i < 8; i++) begin
        r[i] = rand_bits(8);
        write_reg(reg_addr_t'(i), r[i]);
    end
    query(0, 1'b1);
    check_tl("o_tl", tl, r[2][5:0]);
    check_fb("o_fb", fb, r[3][2:0]);
    check_bit("o_dc", dc, r[3][4]);
    check_bit("o_dm", dm, r[3][3]);
    check_bit("o_am", am, r[0][7]);
    check_bit("o_pm", pm, r[0][6]);
    check_bit("o_etyp", etyp, r[0][5]);
    check_bit("o_ksr", ksr, r[0][4]);
    check_ksl("o_ksl", ksl, r[2][7:6]);
    check_mul("o_mul", mul, r[0][3:0]);
    check_rates(r[4][7:4], r[4][3:0], r[6][7:4], r[6][3:0]);
    query(0, 1'b0);
    check_tl("o_tl", tl, 6'h28);
    check_bit("o_am", am, r[1][7]);
    check_bit("o_pm", pm, r[1][6]);
    check_bit("o_etyp", etyp, r[1][5]);
    check_bit("o_ksr", ksr, r[1][4]);
    check_ksl("o_ksl", ksl, r[3][7:6]);
    check_mul("o_mul", mul, r[1][3:0]);
    check_rates(r[5][7:4], r[5][3:0], r[7][7:4], r[7][3:0]);

    // rom patches from the pattern file, channel 2
    if (pat_mem[0] === 8'hxx) begin
        other_errors++;
        $display("pattern file verif/opll_reg_patterns.txt could not be read");
    end
    write_reg(8'h22, 8'h10);
    for (int p = 0; p < N_PAT; p++) begin
        inst_n = pat_mem[p*PAT_COLS][3:0];
        sel    = pat_mem[p*PAT_COLS+1][0];
        write_reg(8'h32, {inst_n, 4'h0});
        query(2, sel);
        check_tl("o_tl", tl, pat_mem[p*PAT_COLS+2][5:0]);
        check_fb("o_fb", fb, pat_mem[p*PAT_COLS+3][2:0]);
        check_mul("o_mul", mul, pat_mem[p*PAT_COLS+4][3:0]);
        check_rates(pat_mem[p*PAT_COLS+5][3:0], pat_mem[p*PAT_COLS+6][3:0],
                    pat_mem[p*PAT_COLS+7][3:0], pat_mem[p*PAT_COLS+8][3:0]);
    end

    // rate mask on an idle melodic modulator, instrument 3
    write_reg(8'h20, 8'h00);
    write_reg(8'h30, 8'h30);
    query(0, 1'b1);
    check_rates('0, '0, 4'h1, '0);
    query(0, 1'b0);
    check_rates(4'hC, 4'h4, 4'h2, 4'h3);

    // rhythm mode, hh only
    write_reg(8'h26, 8'h00);
    write_reg(8'h27, 8'h00);
    write_reg(8'h28, 8'h00);
    write_reg(8'h36, 8'h00);
    write_reg(8'h37, 8'h50);
    write_reg(8'h38, 8'h30);
    write_reg(`OPLL_ADDR_RHYTHM, 8'h21);
    query(7, 1'b1);
    check_bit("o_rhythm_en", rhythm_en, 1'b1);
    check_bit("o_kon", kon, 1'b1);
    check_tl("o_tl", tl, 6'h14);
    check_mul("o_mul", mul, 4'h1);
    check_rates(4'hC, 4'h8, 4'hA, 4'h7);
    query(7, 1'b0);
    check_bit("o_kon", kon, 1'b0);
    check_tl("o_tl", tl, 6'h00);
    check_rates(4'hD, 4'h8, 4'h4, 4'h8);
    query(8, 1'b1);     // tt runs free with key-on low
    check_bit("o_kon", kon, 1'b0);
    check_tl("o_tl", tl, 6'h0C);
    check_mul("o_mul", mul, 4'h5);
    check_rates(4'hF, 4'h8, 4'h5, 4'h9);
    query(6, 1'b1);     // bd0 masked
    check_tl("o_tl", tl, 6'h18);
    check_rates('0, '0, 4'h6, '0);

    // bass drum on
    write_reg(`OPLL_ADDR_RHYTHM, 8'h30);
    query(6, 1'b1);
    check_bit("o_kon", kon, 1'b1);
    check_rates(4'hD, 4'hF, 4'h6, 4'hA);
    query(6, 1'b0);
    check_bit("o_kon", kon, 1'b1);
    check_rates(4'hF, 4'h8, 4'h6, 4'hD);
    query(7, 1'b1);
    check_bit("o_kon", kon, 1'b0);

    repeat (2) @(negedge clk);
    other_errors += DUT.u_bus_sync.u_checker.fail_cnt;
    $display("errors: value mismatches %0d, other failures %0d", errors, other_errors);
    if (errors == 0 && other_errors == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

endmodule

/* verif/opll_reg_patterns.txt */
// inst sel(1=mod) tl fb mul ar dr sl rr, all hex
// carrier rows expect tl 00 since the channel volume is 0
01 1 1E 7 1 D 0 0 0
01 0 00 7 1 7 8 1 7
03 1 19 0 3 F 2 1 1
03 0 00 0 1 C 4 2 3
08 1 2D 4 3 A 2 0 0
08 0 00 4 1 7 2 0 7
0C 1 24 7 7 F 8 2 2
0C 0 00 7 1 F 8 1 2
0F 1 09 3 1 F 1 4 0
0F 0 00 3 1 E 4 1 3

/* tb.f */
+incdir+include
logic/opll_reg_pkg.sv
logic/opll_bus_sync.sv
logic/opll_cust_patch_regs.sv
logic/opll_chan_regs.sv
logic/opll_patch_rom.sv
logic/opll_param_select.sv
logic/opll_reg_top.sv
verif/opll_reg_checker.sv
verif/opll_reg_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module opll_reg_tb -o opll_reg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/opll_reg_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi
exit 0
